// ==== logic/roce_pkg.sv ====
// Shared widths, register map and word layouts of the RoCE command shim
// Core-side words list the highest field first, so the opcode ends up at bit 0
// QPN split is fixed: pid in the low bits, vfid right above it
`default_nettype none

package roce_pkg;

  // Field widths
  localparam int RDMA_OPCODE_BITS = 5;
  localparam int QPN_BITS         = 10;
  localparam int PID_BITS         = 6;
  localparam int VFID_BITS        = 4;
  localparam int VADDR_BITS       = 48;
  localparam int LEN_BITS         = 28;
  localparam int REG_ADDR_BITS    = 3;
  localparam int REG_DATA_BITS    = 32;

  // Register map
  localparam logic [REG_ADDR_BITS-1:0] REG_CTRL        = 3'd0;
  localparam logic [REG_ADDR_BITS-1:0] REG_CREDITS     = 3'd1;
  localparam logic [REG_ADDR_BITS-1:0] REG_LOCAL_IP    = 3'd2;
  localparam logic [REG_ADDR_BITS-1:0] REG_SQ_CNT      = 3'd3;
  localparam logic [REG_ADDR_BITS-1:0] REG_ACK_CNT     = 3'd4;
  localparam logic [REG_ADDR_BITS-1:0] REG_RD_CNT      = 3'd5;
  localparam logic [REG_ADDR_BITS-1:0] REG_WR_CNT      = 3'd6;
  localparam logic [REG_ADDR_BITS-1:0] REG_OUTSTANDING = 3'd7;

  // User send-queue command
  typedef struct packed {
    logic [RDMA_OPCODE_BITS-1:0] opcode;
    logic [QPN_BITS-1:0]         qpn;
    logic                        host;
    logic                        last;
    logic [VADDR_BITS-1:0]       local_vaddr;
    logic [VADDR_BITS-1:0]       remote_vaddr;
    logic [LEN_BITS-1:0]         len;
  } sq_req_t;

  // Core send-queue word, opcode at bit 0
  typedef struct packed {
    logic [LEN_BITS-1:0]   len;
    logic [VADDR_BITS-1:0] remote_vaddr;
    logic [VADDR_BITS-1:0] local_vaddr;
    logic                  last;
    logic                  host;
    logic [QPN_BITS-1:0]   qpn;
    logic [31:0]           opcode;
  } sq_word_t;

  // Core ack word
  typedef struct packed {
    logic                last;
    logic                host;
    logic [QPN_BITS-1:0] qpn;
    logic [31:0]         opcode;
  } ack_word_t;

  // User ack
  typedef struct packed {
    logic [RDMA_OPCODE_BITS-1:0] opcode;
    logic [PID_BITS-1:0]         pid;
    logic [VFID_BITS-1:0]        vfid;
    logic                        host;
    logic                        last;
  } dack_t;

  // Core memory command word, same for read and write
  typedef struct packed {
    logic                  host;
    logic [LEN_BITS-1:0]   len;
    logic [VADDR_BITS-1:0] vaddr;
    logic                  last;
    logic [QPN_BITS-1:0]   qpn;
    logic [31:0]           opcode;
  } mem_word_t;

  // Decoded memory request
  typedef struct packed {
    logic [RDMA_OPCODE_BITS-1:0] opcode;
    logic [PID_BITS-1:0]         pid;
    logic [VFID_BITS-1:0]        vfid;
    logic                        last;
    logic [VADDR_BITS-1:0]       vaddr;
    logic [LEN_BITS-1:0]         len;
    logic                        host;
  } mem_req_t;

  // Register access, strobes last one cycle
  typedef struct packed {
    logic                     wr;
    logic                     rd;
    logic [REG_ADDR_BITS-1:0] addr;
    logic [REG_DATA_BITS-1:0] wdata;
  } reg_bus_t;

  // Datapath transfer strobes for the counters
  typedef struct packed {
    logic sq_fire;
    logic ack_fire;
    logic rd_fire;
    logic wr_fire;
  } stat_evt_t;

endpackage

`default_nettype wire

// ==== logic/meta_reg_slice.sv ====
// One-entry forward register slice with valid/ready on both sides
// Adds exactly one cycle of latency and keeps full throughput
`default_nettype none
`timescale 1ns/100ps

module meta_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     nclk,
  input  logic     reset,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // Free when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  // Valid flag
  always_ff @(posedge nclk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Payload, loaded only on an accepted transfer
  always_ff @(posedge nclk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rdma_flow.sv ====
// Credit flow control between user send queue and the core
// Outstanding never goes below zero, a stray ack is passed on but returns no credit
// Lowering the credit limit below outstanding only blocks new commands
`default_nettype none
`timescale 1ns/100ps

module rdma_flow #(
  parameter int CREDIT_BITS = 8
) (
  input  logic                      nclk,
  input  logic                      reset,

  // User send queue
  input  logic                      usr_sq_valid,
  input  roce_pkg::sq_req_t         usr_sq,
  output logic                      usr_sq_ready,

  // Core send queue
  output logic                      core_sq_valid,
  output roce_pkg::sq_word_t        core_sq,
  input  logic                      core_sq_ready,

  // Core acks
  input  logic                      core_ack_valid,
  input  roce_pkg::ack_word_t       core_ack,
  output logic                      core_ack_ready,

  // User acks
  output logic                      usr_ack_valid,
  output roce_pkg::dack_t           usr_ack,
  input  logic                      usr_ack_ready,

  // Control and status
  input  logic                      enable,
  input  logic [CREDIT_BITS-1:0]    credit_limit,
  output logic [CREDIT_BITS-1:0]    outstanding,
  output logic                      sq_fire,
  output logic                      ack_fire
);

  import roce_pkg::*;

  logic      credit_ok;
  logic      sq_slice_ready;
  sq_word_t  sq_word;
  dack_t     ack_dec;

  // Room for one more command in flight
  assign credit_ok = enable && (outstanding < credit_limit);

  assign usr_sq_ready = credit_ok && sq_slice_ready;
  assign sq_fire      = usr_sq_valid && usr_sq_ready;
  assign ack_fire     = core_ack_valid && core_ack_ready;

  // Pack into the core layout, opcode zero padded to 32 bits
  always_comb begin
    sq_word              = '0;
    sq_word.opcode       = 32'(usr_sq.opcode);
    sq_word.qpn          = usr_sq.qpn;
    sq_word.host         = usr_sq.host;
    sq_word.last         = usr_sq.last;
    sq_word.local_vaddr  = usr_sq.local_vaddr;
    sq_word.remote_vaddr = usr_sq.remote_vaddr;
    sq_word.len          = usr_sq.len;
  end

  // Ack decode, qpn splits into pid and vfid
  always_comb begin
    ack_dec        = '0;
    ack_dec.opcode = core_ack.opcode[RDMA_OPCODE_BITS-1:0];
    ack_dec.pid    = core_ack.qpn[PID_BITS-1:0];
    ack_dec.vfid   = core_ack.qpn[PID_BITS+:VFID_BITS];
    ack_dec.host   = core_ack.host;
    ack_dec.last   = core_ack.last;
  end

  // Outstanding count, command and ack may land together
  always_ff @(posedge nclk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      case ({sq_fire, ack_fire})
        2'b10: outstanding <= outstanding + CREDIT_BITS'(1);
        2'b01: begin
          if (outstanding != '0) begin
            outstanding <= outstanding - CREDIT_BITS'(1);
          end
        end
        default: outstanding <= outstanding;
      endcase
    end
  end

  // Towards the core
  meta_reg_slice #(
    .payload_t (sq_word_t)
  ) sq_slice_inst (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (usr_sq_valid && credit_ok),
    .in_data   (sq_word),
    .in_ready  (sq_slice_ready),
    .out_valid (core_sq_valid),
    .out_data  (core_sq),
    .out_ready (core_sq_ready)
  );

  // Towards the user
  meta_reg_slice #(
    .payload_t (dack_t)
  ) ack_slice_inst (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (core_ack_valid),
    .in_data   (ack_dec),
    .in_ready  (core_ack_ready),
    .out_valid (usr_ack_valid),
    .out_data  (usr_ack),
    .out_ready (usr_ack_ready)
  );

endmodule

`default_nettype wire

// ==== logic/mem_cmd_path.sv ====
// Decodes core read and write memory commands into requests
// Both paths are independent, each with one cycle of latency
`default_nettype none
`timescale 1ns/100ps

module mem_cmd_path (
  input  logic                 nclk,
  input  logic                 reset,

  // Core command words
  input  logic                 core_rd_valid,
  input  roce_pkg::mem_word_t  core_rd,
  output logic                 core_rd_ready,
  input  logic                 core_wr_valid,
  input  roce_pkg::mem_word_t  core_wr,
  output logic                 core_wr_ready,

  // Decoded requests
  output logic                 rd_valid,
  output roce_pkg::mem_req_t   rd_req,
  input  logic                 rd_ready,
  output logic                 wr_valid,
  output roce_pkg::mem_req_t   wr_req,
  input  logic                 wr_ready,

  // Event strobes
  output logic                 rd_fire,
  output logic                 wr_fire
);

  import roce_pkg::*;

  // Same field split for reads and writes
  function automatic mem_req_t decode_cmd(input mem_word_t w);
    mem_req_t r;
    r        = '0;
    r.opcode = w.opcode[RDMA_OPCODE_BITS-1:0];
    r.pid    = w.qpn[PID_BITS-1:0];
    r.vfid   = w.qpn[PID_BITS+:VFID_BITS];
    r.last   = w.last;
    r.vaddr  = w.vaddr;
    r.len    = w.len;
    r.host   = w.host;
    return r;
  endfunction

  assign rd_fire = core_rd_valid && core_rd_ready;
  assign wr_fire = core_wr_valid && core_wr_ready;

  // Read commands
  meta_reg_slice #(
    .payload_t (mem_req_t)
  ) rd_slice_inst (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (core_rd_valid),
    .in_data   (decode_cmd(core_rd)),
    .in_ready  (core_rd_ready),
    .out_valid (rd_valid),
    .out_data  (rd_req),
    .out_ready (rd_ready)
  );

  // Write commands
  meta_reg_slice #(
    .payload_t (mem_req_t)
  ) wr_slice_inst (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (core_wr_valid),
    .in_data   (decode_cmd(core_wr)),
    .in_ready  (core_wr_ready),
    .out_valid (wr_valid),
    .out_data  (wr_req),
    .out_ready (wr_ready)
  );

endmodule

`default_nettype wire

// ==== logic/roce_ctrl_regs.sv ====
// Control registers and event counters of the shim
// Read data returns one cycle after the read strobe, counters wrap at 32 bits
// Writes to counter and outstanding addresses have no effect
`default_nettype none
`timescale 1ns/100ps

module roce_ctrl_regs #(
  parameter int CREDIT_BITS     = 8,
  parameter int DEFAULT_CREDITS = 8
) (
  input  logic                                nclk,
  input  logic                                reset,

  // Register access
  input  roce_pkg::reg_bus_t                  reg_bus,
  output logic [roce_pkg::REG_DATA_BITS-1:0]  reg_rdata,
  output logic                                reg_rvalid,

  // Towards flow control and core
  output logic                                enable,
  output logic [CREDIT_BITS-1:0]              credit_limit,
  output logic [127:0]                        core_local_ip,

  // Status in
  input  logic [CREDIT_BITS-1:0]              outstanding,
  input  roce_pkg::stat_evt_t                 stats
);

  import roce_pkg::*;

  logic [REG_DATA_BITS-1:0] local_ip;
  logic [REG_DATA_BITS-1:0] evt_cnt [4];
  logic [3:0]               evt;
  logic [REG_DATA_BITS-1:0] rd_mux;

  // Counter order: sq, ack, rd, wr
  assign evt = {stats.wr_fire, stats.rd_fire, stats.ack_fire, stats.sq_fire};

  // IPv4 address, four copies on the core port
  assign core_local_ip = {4{local_ip}};

  // Writable registers
  always_ff @(posedge nclk) begin
    if (reset) begin
      enable       <= 1'b0;
      credit_limit <= CREDIT_BITS'(DEFAULT_CREDITS);
      local_ip     <= '0;
    end else if (reg_bus.wr) begin
      case (reg_bus.addr)
        REG_CTRL:     enable       <= reg_bus.wdata[0];
        REG_CREDITS:  credit_limit <= reg_bus.wdata[CREDIT_BITS-1:0];
        REG_LOCAL_IP: local_ip     <= reg_bus.wdata;
        default:      ;
      endcase
    end
  end

  // Event counters
  always_ff @(posedge nclk) begin
    for (int i = 0; i < 4; i++) begin
      if (reset) begin
        evt_cnt[i] <= '0;
      end else if (evt[i]) begin
        evt_cnt[i] <= evt_cnt[i] + 1'b1;
      end
    end
  end

  // Read select
  always_comb begin
    rd_mux = '0;
    case (reg_bus.addr)
      REG_CTRL:        rd_mux = REG_DATA_BITS'(enable);
      REG_CREDITS:     rd_mux = REG_DATA_BITS'(credit_limit);
      REG_LOCAL_IP:    rd_mux = local_ip;
      REG_SQ_CNT:      rd_mux = evt_cnt[0];
      REG_ACK_CNT:     rd_mux = evt_cnt[1];
      REG_RD_CNT:      rd_mux = evt_cnt[2];
      REG_WR_CNT:      rd_mux = evt_cnt[3];
      REG_OUTSTANDING: rd_mux = REG_DATA_BITS'(outstanding);
      default:         rd_mux = '0;
    endcase
  end

  // Registered read port
  always_ff @(posedge nclk) begin
    if (reset) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_bus.rd;
    end
  end

  always_ff @(posedge nclk) begin
    if (reg_bus.rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== logic/roce_shim_top.sv ====
// Command shim between user logic and the RoCE core boundary
// Every valid/ready port transfers when both are high on the clock edge
`default_nettype none
`timescale 1ns/100ps

module roce_shim_top #(
  parameter int DEFAULT_CREDITS = 8,
  parameter int CREDIT_BITS     = 8
) (
  input  logic                                nclk,
  input  logic                                reset,

  // User send queue and acks
  input  logic                                usr_sq_valid,
  input  roce_pkg::sq_req_t                   usr_sq,
  output logic                                usr_sq_ready,
  output logic                                usr_ack_valid,
  output roce_pkg::dack_t                     usr_ack,
  input  logic                                usr_ack_ready,

  // Core boundary
  output logic                                core_sq_valid,
  output roce_pkg::sq_word_t                  core_sq,
  input  logic                                core_sq_ready,
  input  logic                                core_ack_valid,
  input  roce_pkg::ack_word_t                 core_ack,
  output logic                                core_ack_ready,
  input  logic                                core_rd_cmd_valid,
  input  roce_pkg::mem_word_t                 core_rd_cmd,
  output logic                                core_rd_cmd_ready,
  input  logic                                core_wr_cmd_valid,
  input  roce_pkg::mem_word_t                 core_wr_cmd,
  output logic                                core_wr_cmd_ready,
  output logic [127:0]                        core_local_ip,

  // Memory requests
  output logic                                mem_rd_req_valid,
  output roce_pkg::mem_req_t                  mem_rd_req,
  input  logic                                mem_rd_req_ready,
  output logic                                mem_wr_req_valid,
  output roce_pkg::mem_req_t                  mem_wr_req,
  input  logic                                mem_wr_req_ready,

  // Registers
  input  roce_pkg::reg_bus_t                  reg_bus,
  output logic [roce_pkg::REG_DATA_BITS-1:0]  reg_rdata,
  output logic                                reg_rvalid
);

  import roce_pkg::*;

  logic                   enable;
  logic [CREDIT_BITS-1:0] credit_limit;
  logic [CREDIT_BITS-1:0] outstanding;
  stat_evt_t              stats;

  // Send queue and acks with credits
  rdma_flow #(
    .CREDIT_BITS (CREDIT_BITS)
  ) rdma_flow_inst (
    .nclk           (nclk),
    .reset          (reset),
    .usr_sq_valid   (usr_sq_valid),
    .usr_sq         (usr_sq),
    .usr_sq_ready   (usr_sq_ready),
    .core_sq_valid  (core_sq_valid),
    .core_sq        (core_sq),
    .core_sq_ready  (core_sq_ready),
    .core_ack_valid (core_ack_valid),
    .core_ack       (core_ack),
    .core_ack_ready (core_ack_ready),
    .usr_ack_valid  (usr_ack_valid),
    .usr_ack        (usr_ack),
    .usr_ack_ready  (usr_ack_ready),
    .enable         (enable),
    .credit_limit   (credit_limit),
    .outstanding    (outstanding),
    .sq_fire        (stats.sq_fire),
    .ack_fire       (stats.ack_fire)
  );

  // Memory command decode
  mem_cmd_path mem_cmd_path_inst (
    .nclk          (nclk),
    .reset         (reset),
    .core_rd_valid (core_rd_cmd_valid),
    .core_rd       (core_rd_cmd),
    .core_rd_ready (core_rd_cmd_ready),
    .core_wr_valid (core_wr_cmd_valid),
    .core_wr       (core_wr_cmd),
    .core_wr_ready (core_wr_cmd_ready),
    .rd_valid      (mem_rd_req_valid),
    .rd_req        (mem_rd_req),
    .rd_ready      (mem_rd_req_ready),
    .wr_valid      (mem_wr_req_valid),
    .wr_req        (mem_wr_req),
    .wr_ready      (mem_wr_req_ready),
    .rd_fire       (stats.rd_fire),
    .wr_fire       (stats.wr_fire)
  );

  // Control and statistics
  roce_ctrl_regs #(
    .CREDIT_BITS     (CREDIT_BITS),
    .DEFAULT_CREDITS (DEFAULT_CREDITS)
  ) roce_ctrl_regs_inst (
    .nclk          (nclk),
    .reset         (reset),
    .reg_bus       (reg_bus),
    .reg_rdata     (reg_rdata),
    .reg_rvalid    (reg_rvalid),
    .enable        (enable),
    .credit_limit  (credit_limit),
    .core_local_ip (core_local_ip),
    .outstanding   (outstanding),
    .stats         (stats)
  );

endmodule

`default_nettype wire

// ==== testbench/roce_shim_assertions.sv ====
// Protocol checks for rdma_flow, bound into every rdma_flow instance
// Assumes the credit limit is never lowered below outstanding during a run
`default_nettype none
`timescale 1ns/100ps

module roce_shim_assertions #(
  parameter int CREDIT_BITS = 8
) (
  input logic                   nclk,
  input logic                   reset,
  input logic                   enable,
  input logic [CREDIT_BITS-1:0] credit_limit,
  input logic [CREDIT_BITS-1:0] outstanding,
  input logic                   core_sq_valid,
  input roce_pkg::sq_word_t     core_sq,
  input logic                   core_sq_ready,
  input logic                   usr_ack_valid,
  input roce_pkg::dack_t        usr_ack,
  input logic                   usr_ack_ready
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // Core send queue holds its word until taken
  sq_hold: assert property (@(posedge nclk) disable iff (reset)
    core_sq_valid && !core_sq_ready |=> core_sq_valid && $stable(core_sq))
    else begin
      $error("core_sq dropped or changed its word under back-pressure");
      fail_count++;
    end

  // Same for acks towards the user
  ack_hold: assert property (@(posedge nclk) disable iff (reset)
    usr_ack_valid && !usr_ack_ready |=> usr_ack_valid && $stable(usr_ack))
    else begin
      $error("usr_ack dropped or changed its ack under back-pressure");
      fail_count++;
    end

  // Never more commands in flight than credits
  credit_bound: assert property (@(posedge nclk) disable iff (reset)
    outstanding <= credit_limit)
    else begin
      $error("outstanding count went above the credit limit");
      fail_count++;
    end

  // A new word needs enable at its acceptance
  sq_needs_enable: assert property (@(posedge nclk) disable iff (reset)
    $rose(core_sq_valid) |-> $past(enable))
    else begin
      $error("core_sq_valid rose although enable was low");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== testbench/roce_shim_tb.sv ====
// Testbench for the RoCE command shim, built with DEFAULT_CREDITS of 4
// Inputs change 1 ns after the rising edge, monitors sample at the falling edge
// Every input transfer queues its expected output, outputs are checked in order
`default_nettype none
`timescale 1ns/100ps

module roce_shim_tb;

  import roce_pkg::*;

  localparam int TIMEOUT   = 500;
  localparam int PORT_SQ   = 0;
  localparam int PORT_ACK  = 1;
  localparam int PORT_RD   = 2;
  localparam int PORT_WR   = 3;

  logic                     nclk = 1'b0;
  logic                     reset;
  logic                     usr_sq_valid;
  sq_req_t                  usr_sq;
  logic                     usr_sq_ready;
  logic                     usr_ack_valid;
  dack_t                    usr_ack;
  logic                     usr_ack_ready;
  logic                     core_sq_valid;
  sq_word_t                 core_sq;
  logic                     core_sq_ready;
  logic                     core_ack_valid;
  ack_word_t                core_ack;
  logic                     core_ack_ready;
  logic                     core_rd_cmd_valid;
  mem_word_t                core_rd_cmd;
  logic                     core_rd_cmd_ready;
  logic                     core_wr_cmd_valid;
  mem_word_t                core_wr_cmd;
  logic                     core_wr_cmd_ready;
  logic [127:0]             core_local_ip;
  logic                     mem_rd_req_valid;
  mem_req_t                 mem_rd_req;
  logic                     mem_rd_req_ready;
  logic                     mem_wr_req_valid;
  mem_req_t                 mem_wr_req;
  logic                     mem_wr_req_ready;
  reg_bus_t                 reg_bus;
  logic [REG_DATA_BITS-1:0] reg_rdata;
  logic                     reg_rvalid;

  // Random back-pressure on all four output ports when set
  logic        random_ready;
  // Expected outputs in order
  sq_word_t    sq_exp[$];
  dack_t       ack_exp[$];
  mem_req_t    rd_exp[$];
  mem_req_t    wr_exp[$];
  // Commands sent per port
  int unsigned n_sq;
  int unsigned n_ack;
  int unsigned n_rd;
  int unsigned n_wr;
  sq_req_t     held_req;
  logic [31:0] ip;

  always #2 nclk = ~nclk;

  roce_shim_top #(
    .DEFAULT_CREDITS (4)
  ) roce_shim_top_inst (.*);

  bind rdma_flow roce_shim_assertions #(
    .CREDIT_BITS (CREDIT_BITS)
  ) flow_checks_inst (
    .nclk          (nclk),
    .reset         (reset),
    .enable        (enable),
    .credit_limit  (credit_limit),
    .outstanding   (outstanding),
    .core_sq_valid (core_sq_valid),
    .core_sq       (core_sq),
    .core_sq_ready (core_sq_ready),
    .usr_ack_valid (usr_ack_valid),
    .usr_ack       (usr_ack),
    .usr_ack_ready (usr_ack_ready)
  );

  // Core layout from bit 0 up: 32-bit opcode, qpn, host, last, local, remote, len
  function automatic sq_word_t pack_model(input sq_req_t r);
    return {r.len, r.remote_vaddr, r.local_vaddr, r.last, r.host, r.qpn, 27'd0, r.opcode};
  endfunction

  // qpn[5:0] is the pid, qpn[9:6] the vfid
  function automatic dack_t ack_model(input ack_word_t w);
    return {w.opcode[4:0], w.qpn[5:0], w.qpn[9:6], w.host, w.last};
  endfunction

  function automatic mem_req_t mem_model(input mem_word_t w);
    return {w.opcode[4:0], w.qpn[5:0], w.qpn[9:6], w.last, w.vaddr, w.len, w.host};
  endfunction

  function automatic logic [255:0] rand_bits();
    logic [255:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i*32 +: 32] = $urandom;
    end
    return r;
  endfunction

  function automatic sq_req_t rand_sq();
    logic [255:0] r;
    r = rand_bits();
    return r[$bits(sq_req_t)-1:0];
  endfunction

  // Full 32-bit opcode field, upper bits must be dropped by the decode
  function automatic ack_word_t rand_ack();
    logic [255:0] r;
    r = rand_bits();
    return r[$bits(ack_word_t)-1:0];
  endfunction

  function automatic mem_word_t rand_mem();
    logic [255:0] r;
    r = rand_bits();
    return r[$bits(mem_word_t)-1:0];
  endfunction

  function automatic logic port_ready(input int port);
    case (port)
      PORT_SQ:  return usr_sq_ready;
      PORT_ACK: return core_ack_ready;
      PORT_RD:  return core_rd_cmd_ready;
      default:  return core_wr_cmd_ready;
    endcase
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  // Returns 1 ns after the edge that takes the item
  task automatic wait_ready(input int port, input string what);
    int waited;
    waited = 0;
    @(negedge nclk);
    while (!port_ready(port)) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("Timed out waiting for %s to be accepted", what));
      end
      @(negedge nclk);
    end
    @(posedge nclk);
    #1;
  endtask

  task automatic send_sq(input sq_req_t req);
    usr_sq       = req;
    usr_sq_valid = 1'b1;
    wait_ready(PORT_SQ, "usr_sq");
    usr_sq_valid = 1'b0;
    n_sq++;
  endtask

  task automatic send_ack(input ack_word_t w);
    core_ack       = w;
    core_ack_valid = 1'b1;
    wait_ready(PORT_ACK, "core_ack");
    core_ack_valid = 1'b0;
    n_ack++;
  endtask

  task automatic send_rd(input mem_word_t w);
    core_rd_cmd       = w;
    core_rd_cmd_valid = 1'b1;
    wait_ready(PORT_RD, "core_rd_cmd");
    core_rd_cmd_valid = 1'b0;
    n_rd++;
  endtask

  task automatic send_wr(input mem_word_t w);
    core_wr_cmd       = w;
    core_wr_cmd_valid = 1'b1;
    wait_ready(PORT_WR, "core_wr_cmd");
    core_wr_cmd_valid = 1'b0;
    n_wr++;
  endtask

  task automatic reg_write(input logic [REG_ADDR_BITS-1:0] addr, input logic [31:0] data);
    reg_bus.wr    = 1'b1;
    reg_bus.addr  = addr;
    reg_bus.wdata = data;
    @(posedge nclk);
    #1;
    reg_bus.wr = 1'b0;
  endtask

  task automatic reg_check(input logic [REG_ADDR_BITS-1:0] addr, input logic [31:0] exp);
    int waited;
    reg_bus.rd   = 1'b1;
    reg_bus.addr = addr;
    @(posedge nclk);
    #1;
    reg_bus.rd = 1'b0;
    waited = 0;
    @(negedge nclk);
    while (!reg_rvalid) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("Register read of address %0d never returned", addr));
      end
      @(negedge nclk);
    end
    assert (reg_rdata == exp) else stop_with_failure($sformatf(
      "[ERROR] reg_rdata at address %0d got 0x%h expected 0x%h", addr, reg_rdata, exp));
    @(posedge nclk);
    #1;
  endtask

  // Command held while usr_sq_ready must stay low
  task automatic expect_sq_blocked(input int cycles);
    repeat (cycles) begin
      @(negedge nclk);
      assert (!usr_sq_ready) else stop_with_failure($sformatf(
        "[ERROR] usr_sq_ready got 0x%h expected 0x0", usr_sq_ready));
    end
    @(posedge nclk);
    #1;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge nclk);
    while (sq_exp.size() + ack_exp.size() + rd_exp.size() + wr_exp.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure("Timed out waiting for expected outputs to appear");
      end
      @(negedge nclk);
    end
    @(posedge nclk);
    #1;
  endtask

  // Back-pressure mode, applied from the next rising edge
  task automatic set_random_ready(input logic value);
    @(negedge nclk);
    random_ready = value;
    @(posedge nclk);
    #1;
  endtask

  // Readies, three in four cycles when random
  always @(posedge nclk) begin
    #1;
    core_sq_ready    = !random_ready || ($urandom % 4 != 0);
    usr_ack_ready    = !random_ready || ($urandom % 4 != 0);
    mem_rd_req_ready = !random_ready || ($urandom % 4 != 0);
    mem_wr_req_ready = !random_ready || ($urandom % 4 != 0);
  end

  // Transfers of the coming edge, inputs queue and outputs compare
  always @(negedge nclk) begin
    if (!reset) begin
      if (usr_sq_valid && usr_sq_ready) begin
        sq_exp.push_back(pack_model(usr_sq));
      end
      if (core_ack_valid && core_ack_ready) begin
        ack_exp.push_back(ack_model(core_ack));
      end
      if (core_rd_cmd_valid && core_rd_cmd_ready) begin
        rd_exp.push_back(mem_model(core_rd_cmd));
      end
      if (core_wr_cmd_valid && core_wr_cmd_ready) begin
        wr_exp.push_back(mem_model(core_wr_cmd));
      end
      if (core_sq_valid && core_sq_ready) begin
        assert (sq_exp.size() != 0) else stop_with_failure("core_sq sent a word nobody queued");
        assert (core_sq == sq_exp[0]) else stop_with_failure($sformatf(
          "[ERROR] core_sq got 0x%h expected 0x%h", core_sq, sq_exp[0]));
        void'(sq_exp.pop_front());
      end
      if (usr_ack_valid && usr_ack_ready) begin
        assert (ack_exp.size() != 0) else stop_with_failure("usr_ack sent an ack nobody queued");
        assert (usr_ack == ack_exp[0]) else stop_with_failure($sformatf(
          "[ERROR] usr_ack got 0x%h expected 0x%h", usr_ack, ack_exp[0]));
        void'(ack_exp.pop_front());
      end
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        assert (rd_exp.size() != 0) else stop_with_failure("mem_rd_req sent a request nobody queued");
        assert (mem_rd_req == rd_exp[0]) else stop_with_failure($sformatf(
          "[ERROR] mem_rd_req got 0x%h expected 0x%h", mem_rd_req, rd_exp[0]));
        void'(rd_exp.pop_front());
      end
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        assert (wr_exp.size() != 0) else stop_with_failure("mem_wr_req sent a request nobody queued");
        assert (mem_wr_req == wr_exp[0]) else stop_with_failure($sformatf(
          "[ERROR] mem_wr_req got 0x%h expected 0x%h", mem_wr_req, wr_exp[0]));
        void'(wr_exp.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(32'h83e379ce));
    reset             = 1'b1;
    usr_sq_valid      = 1'b0;
    usr_sq            = '0;
    usr_ack_ready     = 1'b1;
    core_sq_ready     = 1'b1;
    core_ack_valid    = 1'b0;
    core_ack          = '0;
    core_rd_cmd_valid = 1'b0;
    core_rd_cmd       = '0;
    core_wr_cmd_valid = 1'b0;
    core_wr_cmd       = '0;
    mem_rd_req_ready  = 1'b1;
    mem_wr_req_ready  = 1'b1;
    reg_bus           = '0;
    random_ready      = 1'b0;
    n_sq              = 0;
    n_ack             = 0;
    n_rd              = 0;
    n_wr              = 0;
    repeat (10) @(posedge nclk);
    #1;
    reset = 1'b0;

    // Reset values, then a command offered while disabled
    reg_check(REG_CTRL, 0);
    reg_check(REG_CREDITS, 4);
    reg_check(REG_LOCAL_IP, 0);
    for (int a = 3; a < 8; a++) begin
      reg_check(REG_ADDR_BITS'(a), 0);
    end
    usr_sq       = rand_sq();
    usr_sq_valid = 1'b1;
    expect_sq_blocked(8);
    usr_sq_valid = 1'b0;

    // Packing under random back-pressure, credits come back by acks
    reg_write(REG_CTRL, 1);
    set_random_ready(1'b1);
    repeat (4) send_sq(rand_sq());
    wait_drained();
    reg_check(REG_SQ_CNT, n_sq);
    repeat (4) send_ack(rand_ack());
    wait_drained();
    reg_check(REG_OUTSTANDING, 0);

    // Four credits, the fifth waits for an ack
    set_random_ready(1'b0);
    repeat (4) send_sq(rand_sq());
    held_req     = rand_sq();
    usr_sq       = held_req;
    usr_sq_valid = 1'b1;
    expect_sq_blocked(6);
    reg_check(REG_OUTSTANDING, 4);
    send_ack(rand_ack());
    send_sq(held_req);
    reg_write(REG_CREDITS, 8);
    repeat (4) send_sq(rand_sq());
    wait_drained();
    reg_check(REG_OUTSTANDING, 8);
    reg_check(REG_SQ_CNT, n_sq);

    // Acks with usr_ack_ready toggling
    set_random_ready(1'b1);
    repeat (8) send_ack(rand_ack());
    wait_drained();
    reg_check(REG_ACK_CNT, n_ack);
    reg_check(REG_OUTSTANDING, 0);

    // Read and write commands side by side
    fork
      repeat (12) send_rd(rand_mem());
      repeat (12) send_wr(rand_mem());
    join
    wait_drained();
    reg_check(REG_RD_CNT, n_rd);
    reg_check(REG_WR_CNT, n_wr);

    // Local IP, four copies towards the core
    ip = $urandom;
    reg_write(REG_LOCAL_IP, ip);
    reg_check(REG_LOCAL_IP, ip);
    @(negedge nclk);
    assert (core_local_ip == {4{ip}}) else stop_with_failure($sformatf(
      "[ERROR] core_local_ip got 0x%h expected 0x%h", core_local_ip, {4{ip}}));
    @(posedge nclk);
    #1;

    if (roce_shim_top_inst.rdma_flow_inst.flow_checks_inst.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_with_failure("Protocol assertions on rdma_flow reported failures");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
logic/roce_pkg.sv
logic/meta_reg_slice.sv
logic/rdma_flow.sv
logic/mem_cmd_path.sv
logic/roce_ctrl_regs.sv
logic/roce_shim_top.sv
testbench/roce_shim_assertions.sv
testbench/roce_shim_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks sim.log for the pass line
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module roce_shim_tb -f project.f \
  > "$LOG" 2>&1 \
  && ./obj_dir/Vroce_shim_tb >> "$LOG" 2>&1
cat "$LOG"

grep -qx "Simulation finished: PASS" "$LOG" && exit 0 || exit 1
